// File: verilog.f
+incdir+hw
+incdir+test
hw/simd_alu_pkg.sv
hw/lane_adder.sv
hw/lane_shifter.sv
hw/lane_multiplier.sv
hw/simd_alu.sv
test/simd_alu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f verilog.f --top-module simd_alu_tb -o simd_alu_sim

output=$(./obj_dir/simd_alu_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "all tests passed"; then
	echo "Simulation PASSED"
else
	echo "Simulation FAILED"
	exit 1
fi

// File: test/simd_alu_model.svh
`ifndef SIMD_ALU_MODEL_SVH
`define SIMD_ALU_MODEL_SVH

// Lane 0 is the most significant lane of the word
function automatic logic [63:0] mask_for(input int bits);
	if (bits >= 64) begin
		return {64{1'b1}};
	end
	return (64'd1 << bits) - 64'd1;
endfunction

function automatic logic [63:0] extract_lane(input logic [63:0] word, input int bits,
		input int idx);
	return (word >> (64 - bits * (idx + 1))) & mask_for(bits);
endfunction

function automatic logic [63:0] insert_lane(input logic [63:0] word, input int bits,
		input int idx, input logic [63:0] value);
	int pos;
	pos = 64 - bits * (idx + 1);
	return (word & ~(mask_for(bits) << pos)) | ((value & mask_for(bits)) << pos);
endfunction

function automatic int width_bits(input lane_width_t w);
	case (w)
		WIDTH_8: return 8;
		WIDTH_16: return 16;
		WIDTH_32: return 32;
		default: return 64;
	endcase
endfunction

function automatic logic [63:0] add_lanes(input logic [63:0] a, input logic [63:0] b,
		input int bits, input logic sub);
	logic [63:0] res;
	logic [63:0] x;
	logic [63:0] y;
	res = '0;
	for (int i = 0; i < 64 / bits; i++) begin
		x = extract_lane(a, bits, i);
		y = extract_lane(b, bits, i);
		// Wraparound comes from the lane mask in insert_lane
		res = insert_lane(res, bits, i, sub ? x - y : x + y);
	end
	return res;
endfunction

function automatic logic [63:0] shift_lanes(input logic [63:0] a, input logic [63:0] b,
		input int bits, input shift_op_t op);
	logic [63:0] res;
	logic [63:0] x;
	logic [63:0] r;
	int amt;
	res = '0;
	for (int i = 0; i < 64 / bits; i++) begin
		x = extract_lane(a, bits, i);
		amt = int'(extract_lane(b, bits, i) % bits);
		case (op)
			SLL: r = x << amt;
			SRL: r = x >> amt;
			SRA: begin
				r = x >> amt;
				if (x[bits - 1]) begin
					r = r | (mask_for(bits) & ~(mask_for(bits) >> amt));
				end
			end
			default: r = (x << (bits / 2)) | (x >> (bits / 2));
		endcase
		res = insert_lane(res, bits, i, r);
	end
	return res;
endfunction

function automatic logic [63:0] multiply_lanes(input logic [63:0] a, input logic [63:0] b,
		input int bits, input int odd);
	logic [63:0] res;
	logic [63:0] x;
	logic [63:0] y;
	res = '0;
	if (bits == 64) begin
		return res;
	end
	for (int k = 0; k < 32 / bits; k++) begin
		x = extract_lane(a, bits, 2 * k + odd);
		y = extract_lane(b, bits, 2 * k + odd);
		res = insert_lane(res, 2 * bits, k, x * y);
	end
	return res;
endfunction

function automatic logic [63:0] expected_result(input alu_instr_t ins, input simd_word_t ra,
		input simd_word_t rb);
	logic [63:0] res;
	int bits;
	bits = width_bits(ins.width);
	res = '0;
	if (ins.opcode == `OPC_R_ALU) begin
		case (ins.func)
			VAND: res = ra.d & rb.d;
			VOR: res = ra.d | rb.d;
			VXOR: res = ra.d ^ rb.d;
			VNOT: res = ~ra.d;
			VMOV: res = ra.d;
			VADD: res = add_lanes(ra.d, rb.d, bits, 1'b0);
			VSUB: res = add_lanes(ra.d, rb.d, bits, 1'b1);
			VSLL: res = shift_lanes(ra.d, rb.d, bits, SLL);
			VSRL: res = shift_lanes(ra.d, rb.d, bits, SRL);
			VSRA: res = shift_lanes(ra.d, rb.d, bits, SRA);
			VRTTH: res = shift_lanes(ra.d, rb.d, bits, ROT_HALF);
			VMULEU: res = multiply_lanes(ra.d, rb.d, bits, 0);
			VMULOU: res = multiply_lanes(ra.d, rb.d, bits, 1);
			VSQEU: res = multiply_lanes(ra.d, ra.d, bits, 0);
			VSQOU: res = multiply_lanes(ra.d, ra.d, bits, 1);
			default: res = '0;
		endcase
	end
	return res;
endfunction

`endif

// File: test/simd_alu_tb.sv
`timescale 1ns/1ps
`include "simd_alu_settings.svh"

module simd_alu_tb;

	import simd_alu_pkg::*;

	`include "simd_alu_model.svh"

	localparam int EDGE_STEP_LIMIT = 40;
	localparam int RANDOM_COUNT = 3000;

	logic clk;
	logic rst_n;
	alu_instr_t instr;
	simd_word_t ra;
	simd_word_t rb;
	simd_word_t alu_out;

	integer seed;
	logic [63:0] held_exp;

	simd_alu dut0 (
		.clk(clk),
		.rst_n(rst_n),
		.instr(instr),
		.ra(ra),
		.rb(rb),
		.alu_out(alu_out)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [63:0] exp_val,
			input logic [63:0] act_val);
		if (act_val !== exp_val) begin
			$display("Fail %s: expected %h, actual %h", name, exp_val, act_val);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	// Returns 1 ns after the next rising clock edge
	task automatic wait_rising_edge;
		int steps;
		logic prev;
		steps = 0;
		#0.5;
		prev = clk;
		#1;
		while (!(clk === 1'b1 && prev === 1'b0)) begin
			prev = clk;
			#1;
			steps++;
			if (steps > EDGE_STEP_LIMIT) begin
				$display("Timeout: the clock made no rising edge within %0d ns", steps);
				$display("tests failed");
				$fatal(1);
			end
		end
		#0.5;
	endtask

	function automatic logic [63:0] random_word();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = $random(seed);
		lo = $random(seed);
		return {hi, lo};
	endfunction

	// Drive one instruction and check it one cycle later
	task automatic apply_instr(input string name, input logic [5:0] opc, input logic [5:0] fn,
			input logic [1:0] ww, input logic [63:0] a, input logic [63:0] b);
		alu_instr_t next;
		simd_word_t na;
		simd_word_t nb;
		logic [63:0] next_exp;
		next.opcode = opc;
		next.func = alu_func_t'(fn);
		next.width = lane_width_t'(ww);
		na.d = a;
		nb.d = b;
		next_exp = expected_result(next, na, nb);
		instr = next;
		ra = na;
		rb = nb;
		// Output register still holds the previous result
		#1;
		check_value($sformatf("%s hold", name), held_exp, alu_out.d);
		wait_rising_edge();
		check_value(name, next_exp, alu_out.d);
		held_exp = next_exp;
	endtask

	// Two cycles of reset with a live MOV on the inputs
	task automatic hold_reset(input string name);
		rst_n = 1'b0;
		for (int i = 0; i < 2; i++) begin
			instr.opcode = `OPC_R_ALU;
			instr.func = VMOV;
			instr.width = WIDTH_64;
			ra.d = random_word();
			rb.d = random_word();
			wait_rising_edge();
			check_value($sformatf("%s cycle %0d", name, i), 64'd0, alu_out.d);
		end
		held_exp = '0;
		rst_n = 1'b1;
	endtask

	task automatic apply_random(input int n);
		logic [5:0] opc;
		logic [5:0] fn;
		logic [1:0] ww;
		int pick;
		pick = $unsigned($random(seed)) % 8;
		case (pick)
			0: opc = 6'($random(seed));
			1: opc = `OPC_LOAD;
			2: opc = `OPC_BRANCH_NZ;
			default: opc = `OPC_R_ALU;
		endcase
		pick = $unsigned($random(seed)) % 16;
		if (pick < 14) begin
			fn = 6'($unsigned($random(seed)) % 19);
		end else begin
			fn = 6'($random(seed));
		end
		ww = 2'($random(seed));
		apply_instr($sformatf("random %0d opc %h fn %0d ww %0d", n, opc, fn, ww),
			opc, fn, ww, random_word(), random_word());
	endtask

	initial begin
		seed = 32'h6a1d;
		held_exp = '0;
		rst_n = 1'b0;
		instr = '0;
		ra = '0;
		rb = '0;

		hold_reset("reset at start");

		// Every function code at every width
		for (int fn = 0; fn < 19; fn++) begin
			for (int ww = 0; ww < 4; ww++) begin
				apply_instr($sformatf("sweep fn %0d ww %0d", fn, ww), `OPC_R_ALU, 6'(fn),
					2'(ww), random_word(), random_word());
			end
		end

		// Non-ALU opcodes carry valid-looking ALU functions
		apply_instr("opcode load", `OPC_LOAD, `FN_VADD, `WW_8, random_word(), random_word());
		apply_instr("opcode store", `OPC_STORE, `FN_VADD, `WW_16, random_word(), random_word());
		apply_instr("opcode beqz", `OPC_BRANCH_EZ, `FN_VXOR, `WW_32, random_word(),
			random_word());
		apply_instr("opcode bnez", `OPC_BRANCH_NZ, `FN_VMOV, `WW_64, random_word(),
			random_word());
		apply_instr("opcode nop", `OPC_NOP, `FN_VOR, `WW_8, random_word(), random_word());

		// Corner operands for wraparound and sign fill
		apply_instr("add wrap 8", `OPC_R_ALU, `FN_VADD, `WW_8, {64{1'b1}}, 64'h0101010101010101);
		apply_instr("sub wrap 16", `OPC_R_ALU, `FN_VSUB, `WW_16, 64'd0, 64'h0001000100010001);
		apply_instr("sra fill 32", `OPC_R_ALU, `FN_VSRA, `WW_32, 64'h80000000_80000000,
			64'h0000001f_00000004);
		apply_instr("square max 32", `OPC_R_ALU, `FN_VSQOU, `WW_32, {64{1'b1}}, 64'd0);

		hold_reset("reset mid run");

		for (int n = 0; n < RANDOM_COUNT; n++) begin
			apply_random(n);
		end

		$display("all tests passed");
		$finish;
	end

endmodule

// File: hw/simd_alu.sv
`timescale 1ns/1ps
`include "simd_alu_settings.svh"

module simd_alu (
	input logic clk,
	input logic rst_n,
	input simd_alu_pkg::alu_instr_t instr,
	input simd_alu_pkg::simd_word_t ra,
	input simd_alu_pkg::simd_word_t rb,
	output simd_alu_pkg::simd_word_t alu_out
);

	import simd_alu_pkg::*;

	logic sub_sel;
	logic mul_odd;
	shift_op_t shift_op;
	simd_word_t mul_b;
	simd_word_t add_res;
	simd_word_t shift_res;
	simd_word_t mul_res;
	simd_word_t next_out;

	// Controls for the lane units
	assign sub_sel = (instr.func == VSUB);
	assign mul_odd = (instr.func == VMULOU) || (instr.func == VSQOU);

	// Squares reuse the multiplier with ra on both inputs
	assign mul_b = (instr.func == VSQEU || instr.func == VSQOU) ? ra : rb;

	always_comb begin
		case (instr.func)
			VSRL: shift_op = SRL;
			VSRA: shift_op = SRA;
			VRTTH: shift_op = ROT_HALF;
			default: shift_op = SLL;
		endcase
	end

	lane_adder add0 (
		.a(ra),
		.b(rb),
		.width(instr.width),
		.subtract(sub_sel),
		.result(add_res)
	);

	lane_shifter shift0 (
		.a(ra),
		.b(rb),
		.width(instr.width),
		.op(shift_op),
		.result(shift_res)
	);

	lane_multiplier mul0 (
		.a(ra),
		.b(mul_b),
		.width(instr.width),
		.odd(mul_odd),
		.result(mul_res)
	);

	// Result select
	always_comb begin
		next_out = '0;
		case (instr.opcode)
			`OPC_R_ALU: begin
				case (instr.func)
					VAND: next_out.d = ra.d & rb.d;
					VOR: next_out.d = ra.d | rb.d;
					VXOR: next_out.d = ra.d ^ rb.d;
					VNOT: next_out.d = ~ra.d;
					VMOV: next_out = ra;
					VADD, VSUB: next_out = add_res;
					VSLL, VSRL, VSRA, VRTTH: next_out = shift_res;
					VMULEU, VMULOU, VSQEU, VSQOU: next_out = mul_res;
					// VNOP, VDIV, VMOD, VSQRT and unknown codes
					default: next_out = '0;
				endcase
			end
			// Memory, branch and nop slots carry no ALU result
			default: begin
				next_out = '0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			alu_out <= '0;
		end else begin
			alu_out <= next_out;
		end
	end

endmodule

// File: hw/lane_multiplier.sv
`timescale 1ns/1ps

module lane_multiplier (
	input simd_alu_pkg::simd_word_t a,
	input simd_alu_pkg::simd_word_t b,
	input simd_alu_pkg::lane_width_t width,
	input logic odd,
	output simd_alu_pkg::simd_word_t result
);

	import simd_alu_pkg::*;

	// Source lane 2k or 2k+1 feeds double-width result lane k
	always_comb begin
		result = '0;
		case (width)
			WIDTH_8: begin
				for (int k = 0; k < 4; k++) begin
					result.h[k] = a.b[2 * k + odd] * b.b[2 * k + odd];
				end
			end
			WIDTH_16: begin
				for (int k = 0; k < 2; k++) begin
					result.w[k] = a.h[2 * k + odd] * b.h[2 * k + odd];
				end
			end
			WIDTH_32: begin
				result.d = a.w[odd] * b.w[odd];
			end
			// No 128-bit product lane
			WIDTH_64: begin
				result = '0;
			end
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

// File: hw/lane_shifter.sv
`timescale 1ns/1ps

module lane_shifter (
	input simd_alu_pkg::simd_word_t a,
	input simd_alu_pkg::simd_word_t b,
	input simd_alu_pkg::lane_width_t width,
	input simd_alu_pkg::shift_op_t op,
	output simd_alu_pkg::simd_word_t result
);

	import simd_alu_pkg::*;

	// Shift amount is the low log2(lane) bits of the matching b lane
	always_comb begin
		result = '0;
		case (width)
			WIDTH_8: begin
				for (int i = 0; i < 8; i++) begin
					case (op)
						SLL: result.b[i] = a.b[i] << b.b[i][2:0];
						SRL: result.b[i] = a.b[i] >> b.b[i][2:0];
						SRA: result.b[i] = $signed(a.b[i]) >>> b.b[i][2:0];
						ROT_HALF: result.b[i] = {a.b[i][3:0], a.b[i][7:4]};
						default: result.b[i] = '0;
					endcase
				end
			end
			WIDTH_16: begin
				for (int i = 0; i < 4; i++) begin
					case (op)
						SLL: result.h[i] = a.h[i] << b.h[i][3:0];
						SRL: result.h[i] = a.h[i] >> b.h[i][3:0];
						SRA: result.h[i] = $signed(a.h[i]) >>> b.h[i][3:0];
						ROT_HALF: result.h[i] = {a.h[i][7:0], a.h[i][15:8]};
						default: result.h[i] = '0;
					endcase
				end
			end
			WIDTH_32: begin
				for (int i = 0; i < 2; i++) begin
					case (op)
						SLL: result.w[i] = a.w[i] << b.w[i][4:0];
						SRL: result.w[i] = a.w[i] >> b.w[i][4:0];
						SRA: result.w[i] = $signed(a.w[i]) >>> b.w[i][4:0];
						ROT_HALF: result.w[i] = {a.w[i][15:0], a.w[i][31:16]};
						default: result.w[i] = '0;
					endcase
				end
			end
			WIDTH_64: begin
				case (op)
					SLL: result.d = a.d << b.d[5:0];
					SRL: result.d = a.d >> b.d[5:0];
					SRA: result.d = $signed(a.d) >>> b.d[5:0];
					ROT_HALF: result.d = {a.d[31:0], a.d[63:32]};
					default: result.d = '0;
				endcase
			end
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

// File: hw/lane_adder.sv
`timescale 1ns/1ps

module lane_adder (
	input simd_alu_pkg::simd_word_t a,
	input simd_alu_pkg::simd_word_t b,
	input simd_alu_pkg::lane_width_t width,
	input logic subtract,
	output simd_alu_pkg::simd_word_t result
);

	import simd_alu_pkg::*;

	simd_word_t b_eff;

	// Subtract as a + ~b + 1 with a carry in to every lane
	assign b_eff.d = subtract ? ~b.d : b.d;

	always_comb begin
		result = '0;
		case (width)
			WIDTH_8: begin
				for (int i = 0; i < 8; i++) begin
					result.b[i] = a.b[i] + b_eff.b[i] + 8'(subtract);
				end
			end
			WIDTH_16: begin
				for (int i = 0; i < 4; i++) begin
					result.h[i] = a.h[i] + b_eff.h[i] + 16'(subtract);
				end
			end
			WIDTH_32: begin
				for (int i = 0; i < 2; i++) begin
					result.w[i] = a.w[i] + b_eff.w[i] + 32'(subtract);
				end
			end
			WIDTH_64: begin
				result.d = a.d + b_eff.d + 64'(subtract);
			end
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

// File: hw/simd_alu_pkg.sv
`include "simd_alu_settings.svh"

package simd_alu_pkg;

	// One operand word with lane 0 in the most significant bits
	typedef union packed {
		logic [`SIMD_WORD_BITS-1:0] d;
		logic [0:`SIMD_WORD_BITS/32-1][31:0] w;
		logic [0:`SIMD_WORD_BITS/16-1][15:0] h;
		logic [0:`SIMD_WORD_BITS/8-1][7:0] b;
	} simd_word_t;

	typedef enum logic [1:0] {
		WIDTH_8 = `WW_8,
		WIDTH_16 = `WW_16,
		WIDTH_32 = `WW_32,
		WIDTH_64 = `WW_64
	} lane_width_t;

	typedef enum logic [5:0] {
		VNOP = `FN_VNOP,
		VAND = `FN_VAND,
		VOR = `FN_VOR,
		VXOR = `FN_VXOR,
		VNOT = `FN_VNOT,
		VMOV = `FN_VMOV,
		VADD = `FN_VADD,
		VSUB = `FN_VSUB,
		VMULEU = `FN_VMULEU,
		VMULOU = `FN_VMULOU,
		VSLL = `FN_VSLL,
		VSRL = `FN_VSRL,
		VSRA = `FN_VSRA,
		VRTTH = `FN_VRTTH,
		VDIV = `FN_VDIV,
		VMOD = `FN_VMOD,
		VSQEU = `FN_VSQEU,
		VSQOU = `FN_VSQOU,
		VSQRT = `FN_VSQRT
	} alu_func_t;

	// Opcode first, as in the instruction word
	typedef struct packed {
		logic [5:0] opcode;
		alu_func_t func;
		lane_width_t width;
	} alu_instr_t;

	typedef enum logic [1:0] {
		SLL = 2'd0,
		SRL = 2'd1,
		SRA = 2'd2,
		ROT_HALF = 2'd3
	} shift_op_t;

endpackage

// File: hw/simd_alu_settings.svh
`ifndef SIMD_ALU_SETTINGS_SVH
`define SIMD_ALU_SETTINGS_SVH

`define SIMD_WORD_BITS 64

// Major opcode, instruction bits 0 to 5
`define OPC_R_ALU     6'b101010
`define OPC_LOAD      6'b100000
`define OPC_STORE     6'b100001
`define OPC_BRANCH_EZ 6'b100010
`define OPC_BRANCH_NZ 6'b100011
`define OPC_NOP       6'b111100

// R-type function field
`define FN_VNOP   6'b000000
`define FN_VAND   6'b000001
`define FN_VOR    6'b000010
`define FN_VXOR   6'b000011
`define FN_VNOT   6'b000100
`define FN_VMOV   6'b000101
`define FN_VADD   6'b000110
`define FN_VSUB   6'b000111
`define FN_VMULEU 6'b001000
`define FN_VMULOU 6'b001001
`define FN_VSLL   6'b001010
`define FN_VSRL   6'b001011
`define FN_VSRA   6'b001100
`define FN_VRTTH  6'b001101
`define FN_VDIV   6'b001110
`define FN_VMOD   6'b001111
`define FN_VSQEU  6'b010000
`define FN_VSQOU  6'b010001
`define FN_VSQRT  6'b010010

// Lane width field
`define WW_8  2'b00
`define WW_16 2'b01
`define WW_32 2'b10
`define WW_64 2'b11

`endif
